// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = peripherals_tb
FILELIST  = src.f
OBJ_DIR   = obj_dir
PASS_MSG  = sim passed

SOURCES = $(wildcard src/*.sv src/*.svh bench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/peripherals_tb.sv ====
`timescale 1ns/1ns
`include "avr_io_settings.svh"

module peripherals_tb;
   import avr_io_pkg::*;

   localparam int CLK_PERIOD = 10;
   // Cycle budget of reset and the six tests, in run order
   localparam int TEST_CYCLES = 3 + 10 + 80 + 60 + 320 + 400 + 150;
   localparam int TIMEOUT_CYCLES = 5 * TEST_CYCLES;

   logic     rst;
   logic     cp2;
   io_adr_t  adr;
   logic     iore;
   logic     iowe;
   io_data_t dbus_in;
   irq_vec_t irq_ack;
   io_data_t porta_pinx;
   logic     wdri;
   logic     out_en;
   io_data_t dbus_out;
   irq_vec_t irqlines;
   io_data_t porta_portx;
   io_data_t porta_ddrx;
   logic     wdt_wdovf;

   int          errors = 0;
   int          checks = 0;
   logic [31:0] lcg_state = 32'hbb8e1e22;
   io_data_t    ddra_last;
   io_data_t    tcnt0_held;

   peripherals dut_i (
      .rst         (rst),
      .cp2         (cp2),
      .adr         (adr),
      .iore        (iore),
      .iowe        (iowe),
      .dbus_in     (dbus_in),
      .irq_ack     (irq_ack),
      .porta_pinx  (porta_pinx),
      .wdri        (wdri),
      .out_en      (out_en),
      .dbus_out    (dbus_out),
      .irqlines    (irqlines),
      .porta_portx (porta_portx),
      .porta_ddrx  (porta_ddrx),
      .wdt_wdovf   (wdt_wdovf)
   );

   initial cp2 = 1'b0;
   always #(CLK_PERIOD / 2) cp2 = ~cp2;

   // ========================================================================
   // Helpers
   // ========================================================================
   function automatic logic [31:0] next_random();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // Register map of the block
   function automatic logic is_mapped(io_adr_t a);
      return (a == `PORTA_ADR) || (a == `DDRA_ADR) || (a == `PINA_ADR) ||
             (a == `TCCR0_ADR) || (a == `TCNT0_ADR) || (a == `OCR0_ADR) ||
             (a == `WDTCR_ADR);
   endfunction

   function automatic irq_vec_t irq_bit(int pos);
      irq_vec_t v;
      v      = '0;
      v[pos] = 1'b1;
      return v;
   endfunction

   task automatic check_data(string name, io_data_t exp, io_data_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("FAILED %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_bit(string name, logic exp, logic act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("FAILED %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic check_irq(string name, irq_vec_t exp, irq_vec_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("FAILED %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic report_failure(string msg);
      errors++;
      $display("ERROR: %s", msg);
   endtask

   // ========================================================================
   // Bus tasks
   // ========================================================================
   task automatic io_write(io_adr_t a, io_data_t d);
      @(negedge cp2);
      adr     = a;
      dbus_in = d;
      iowe    = 1'b1;
      @(negedge cp2);
      iowe    = 1'b0;
      adr     = '0;
      dbus_in = '0;
   endtask

   task automatic io_read(input io_adr_t a, output io_data_t d, output logic en);
      @(negedge cp2);
      adr  = a;
      iore = 1'b1;
      // Just before the rising edge
      #(CLK_PERIOD / 2 - 1);
      d  = dbus_out;
      en = out_en;
      @(negedge cp2);
      iore = 1'b0;
      adr  = '0;
   endtask

   task automatic read_expect(string name, io_adr_t a, io_data_t exp);
      io_data_t d;
      logic     en;
      io_read(a, d, en);
      check_bit(name, 1'b1, en);
      check_data(name, exp, d);
   endtask

   task automatic pulse_ack(int pos);
      @(negedge cp2);
      irq_ack = irq_bit(pos);
      @(negedge cp2);
      irq_ack = '0;
   endtask

   // ========================================================================
   // Tests
   // ========================================================================
   task automatic test_after_reset();
      io_data_t d;
      logic     en;
      check_irq("reset irqlines", '0, irqlines);
      check_bit("reset wdt_wdovf", 1'b0, wdt_wdovf);
      check_data("reset porta_ddrx", '0, porta_ddrx);
      io_read(6'h00, d, en);
      check_bit("unmapped out_en", 1'b0, en);
      check_data("unmapped data", '0, d);
   endtask

   task automatic test_port_regs();
      logic [31:0] r;
      io_data_t    pa;
      io_data_t    dd;
      io_data_t    pin;
      for (int i = 0; i < 4; i++) begin
         r   = next_random();
         pa  = r[7:0];
         dd  = r[15:8];
         pin = r[23:16];
         io_write(`PORTA_ADR, pa);
         check_data("porta_portx", pa, porta_portx);
         io_write(`DDRA_ADR, dd);
         check_data("porta_ddrx", dd, porta_ddrx);
         read_expect("porta readback", `PORTA_ADR, pa);
         read_expect("ddra readback", `DDRA_ADR, dd);
         ddra_last = dd;
         // Pins settle through the synchronizer
         @(negedge cp2);
         porta_pinx = pin;
         repeat (3) @(negedge cp2);
         read_expect("pina read", `PINA_ADR, pin);
      end
   endtask

   task automatic test_timer_overflow();
      irq_vec_t both;
      both = irq_bit(`TC0_OVF_IRQ) | irq_bit(`TC0_CMP_IRQ);
      io_write(`TCNT0_ADR, 8'd250);
      io_write(`TCCR0_ADR, io_data_t'(TMR_CS_CLK));
      repeat (10) @(negedge cp2);
      // OCR0 is still zero so the wrap to 0 also matches the compare value
      check_irq("overflow set", both, irqlines);
      repeat (20) begin
         @(negedge cp2);
         check_irq("overflow held", both, irqlines);
      end
      pulse_ack(`TC0_OVF_IRQ);
      check_irq("overflow cleared", irq_bit(`TC0_CMP_IRQ), irqlines);
      io_write(`TCCR0_ADR, io_data_t'(TMR_CS_STOP));
      pulse_ack(`TC0_CMP_IRQ);
      check_irq("flags cleared", '0, irqlines);
   endtask

   task automatic test_timer_compare();
      io_data_t first;
      io_data_t second;
      io_data_t stop_cnt;
      logic     en;
      // Ticks every 8 cycles over the 202 cycles between the two TCCR0 writes
      stop_cnt = io_data_t'(202 / 8);
      io_write(`OCR0_ADR, 8'd20);
      io_write(`TCNT0_ADR, 8'd0);
      io_write(`TCCR0_ADR, io_data_t'(TMR_CS_DIV8));
      // 20 ticks of clk/8 take 160 cycles
      repeat (100) @(negedge cp2);
      check_irq("compare early", '0, irqlines);
      repeat (100) @(negedge cp2);
      check_irq("compare set", irq_bit(`TC0_CMP_IRQ), irqlines);
      io_write(`TCCR0_ADR, io_data_t'(TMR_CS_STOP));
      io_read(`TCNT0_ADR, first, en);
      check_bit("tcnt0 read enable", 1'b1, en);
      check_data("tcnt0 at stop", stop_cnt, first);
      repeat (50) @(negedge cp2);
      io_read(`TCNT0_ADR, second, en);
      check_data("tcnt0 held", stop_cnt, second);
      tcnt0_held = stop_cnt;
      pulse_ack(`TC0_CMP_IRQ);
      check_irq("compare cleared", '0, irqlines);
   endtask

   task automatic test_watchdog();
      int early = 0;
      int pulses = 0;
      // WDE set, WDP = 2 gives a 64 cycle period
      io_write(`WDTCR_ADR, 8'h0A);
      read_expect("wdtcr readback", `WDTCR_ADR, 8'h0A);
      for (int i = 0; i < 300; i++) begin
         @(negedge cp2);
         if (wdt_wdovf) early++;
         wdri = (i % 40 == 39);
      end
      if (early != 0) begin
         report_failure($sformatf("watchdog timed out %0d times while restarted", early));
      end
      for (int i = 0; i < 70; i++) begin
         @(negedge cp2);
         wdri = 1'b0;
         if (wdt_wdovf) pulses++;
      end
      if (pulses != 1) begin
         report_failure($sformatf("watchdog gave %0d timeout pulses instead of one", pulses));
      end
      io_write(`WDTCR_ADR, 8'h06);
   endtask

   task automatic test_read_merge();
      io_data_t d;
      logic     en;
      read_expect("merge wdtcr", `WDTCR_ADR, 8'h06);
      read_expect("merge tcnt0", `TCNT0_ADR, tcnt0_held);
      read_expect("merge ddra", `DDRA_ADR, ddra_last);
      for (int a = 0; a < (1 << `IO_ADR_W); a++) begin
         io_read(io_adr_t'(a), d, en);
         check_bit($sformatf("out_en at %h", a), is_mapped(io_adr_t'(a)), en);
         if (!is_mapped(io_adr_t'(a))) begin
            check_data($sformatf("idle data at %h", a), '0, d);
         end
      end
   endtask

   // ========================================================================
   // Main sequence
   // ========================================================================
   initial begin
      rst        = 1'b1;
      adr        = '0;
      iore       = 1'b0;
      iowe       = 1'b0;
      dbus_in    = '0;
      irq_ack    = '0;
      porta_pinx = '0;
      wdri       = 1'b0;
      repeat (3) @(negedge cp2);
      rst = 1'b0;
      test_after_reset();
      test_port_regs();
      test_timer_overflow();
      test_timer_compare();
      test_watchdog();
      test_read_merge();
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

   initial begin
      #(TIMEOUT_CYCLES * CLK_PERIOD);
      $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("checks: %0d, errors: %0d", checks, errors + 1);
      $display("sim failed");
      $finish;
   end

endmodule

// ==== src.f ====
+incdir+src
src/avr_io_pkg.sv
src/io_port.sv
src/timer0.sv
src/wdt.sv
src/io_rd_mux.sv
src/peripherals.sv
bench/peripherals_tb.sv

// ==== src/avr_io_pkg.sv ====
`include "avr_io_settings.svh"

package avr_io_pkg;

   // Bus and interrupt vector types
   typedef logic [`IO_ADR_W-1:0]   io_adr_t;
   typedef logic [`IO_DATA_W-1:0]  io_data_t;
   typedef logic [`IRQS_WIDTH-1:0] irq_vec_t;

   // Timer clock select, CS0[2:0] of TCCR0
   // External clock codes are kept only as stopped
   typedef enum logic [2:0] {
      TMR_CS_STOP     = 3'd0,
      TMR_CS_CLK      = 3'd1,
      TMR_CS_DIV8     = 3'd2,
      TMR_CS_DIV64    = 3'd3,
      TMR_CS_DIV256   = 3'd4,
      TMR_CS_DIV1024  = 3'd5,
      TMR_CS_EXT_FALL = 3'd6,
      TMR_CS_EXT_RISE = 3'd7
   } tmr_cs_t;

endpackage

// ==== src/avr_io_settings.svh ====
`ifndef AVR_IO_SETTINGS_SVH
`define AVR_IO_SETTINGS_SVH

// ==========================================================================
// I/O bus geometry
// ==========================================================================
`define IO_ADR_W    6
`define IO_DATA_W   8
`define IRQS_WIDTH  23
`define IO_SLVS_NUM 3

// ==========================================================================
// Register map
// ==========================================================================
`define PORTA_ADR 6'h1B
`define DDRA_ADR  6'h1A
`define PINA_ADR  6'h19
`define TCCR0_ADR 6'h33
`define TCNT0_ADR 6'h32
`define OCR0_ADR  6'h3C
`define WDTCR_ADR 6'h21

// Timer 0 interrupt positions in irqlines
`define TC0_OVF_IRQ 15
`define TC0_CMP_IRQ 14

// Watchdog period is 2^(WDP + base) cycles
`define WDT_BASE_LOG2 4

`endif

// ==== src/io_port.sv ====
`timescale 1ns/1ns
`include "avr_io_settings.svh"

module io_port (
   input  logic                 rst,
   input  logic                 cp2,
   input  avr_io_pkg::io_adr_t  adr,
   input  logic                 iore,
   input  logic                 iowe,
   input  avr_io_pkg::io_data_t dbus_in,
   input  avr_io_pkg::io_data_t porta_pinx,
   output avr_io_pkg::io_data_t dbus_out,
   output logic                 out_en,
   output avr_io_pkg::io_data_t porta_portx,
   output avr_io_pkg::io_data_t porta_ddrx
);
   import avr_io_pkg::*;

   io_data_t pin_meta;
   io_data_t pin_sync;

   // PORTA and DDRA registers
   always_ff @(posedge cp2) begin
      if (rst) begin
         porta_portx <= '0;
         porta_ddrx  <= '0;
      end else if (iowe) begin
         if (adr == `PORTA_ADR) begin
            porta_portx <= dbus_in;
         end
         if (adr == `DDRA_ADR) begin
            porta_ddrx <= dbus_in;
         end
      end
   end

   // Two-stage pin synchronizer
   always_ff @(posedge cp2) begin
      if (rst) begin
         pin_meta <= '0;
         pin_sync <= '0;
      end else begin
         pin_meta <= porta_pinx;
         pin_sync <= pin_meta;
      end
   end

   always_comb begin
      out_en   = 1'b0;
      dbus_out = '0;
      if (iore) begin
         case (adr)
            `PORTA_ADR: begin
               out_en   = 1'b1;
               dbus_out = porta_portx;
            end
            `DDRA_ADR: begin
               out_en   = 1'b1;
               dbus_out = porta_ddrx;
            end
            `PINA_ADR: begin
               out_en   = 1'b1;
               dbus_out = pin_sync;
            end
            default: ;
         endcase
      end
   end

   // PINA reads see the pins from two edges back
   a_pina_latency: assert property (@(posedge cp2) disable iff (rst)
      (iore && (adr == `PINA_ADR) && !$past(rst) && !$past(rst, 2))
         |-> (dbus_out == $past(porta_pinx, 2)))
      else $error("PINA read does not match the pins two cycles back");

endmodule

// ==== src/io_rd_mux.sv ====
`timescale 1ns/1ns
`include "avr_io_settings.svh"

module io_rd_mux #(
   parameter int N_SLAVES = `IO_SLVS_NUM
) (
   input  logic [N_SLAVES-1:0]  slv_en,
   input  avr_io_pkg::io_data_t slv_data [N_SLAVES-1:0],
   output logic                 out_en,
   output avr_io_pkg::io_data_t dbus_out
);
   import avr_io_pkg::*;

   assign out_en = |slv_en;

   // ========================================================================
   // Priority chain, highest index wins
   // ========================================================================
   always_comb begin
      dbus_out = '0;
      for (int i = 0; i < N_SLAVES; i++) begin
         if (slv_en[i]) begin
            dbus_out = slv_data[i];
         end
      end
   end

   // Overlapping register addresses would show up here
   always_comb begin
      a_one_slave: assert final ($onehot0(slv_en))
         else $error("Several I/O slaves answer one read, en = %b", slv_en);
   end

endmodule

// ==== src/peripherals.sv ====
`timescale 1ns/1ns
`include "avr_io_settings.svh"

module peripherals (
   input  logic                 rst,
   input  logic                 cp2,
   input  avr_io_pkg::io_adr_t  adr,
   input  logic                 iore,
   input  logic                 iowe,
   input  avr_io_pkg::io_data_t dbus_in,
   input  avr_io_pkg::irq_vec_t irq_ack,
   input  avr_io_pkg::io_data_t porta_pinx,
   input  logic                 wdri,
   output logic                 out_en,
   output avr_io_pkg::io_data_t dbus_out,
   output avr_io_pkg::irq_vec_t irqlines,
   output avr_io_pkg::io_data_t porta_portx,
   output avr_io_pkg::io_data_t porta_ddrx,
   output logic                 wdt_wdovf
);
   import avr_io_pkg::*;

   // Read chain order, watchdog on top
   localparam int SLV_PORT = 0;
   localparam int SLV_TMR  = 1;
   localparam int SLV_WDT  = 2;

   logic [`IO_SLVS_NUM-1:0] slv_en;
   io_data_t                slv_data [`IO_SLVS_NUM-1:0];
   logic                    tc0_ovf_irq;
   logic                    tc0_cmp_irq;

   io_port port_a_inst (
      .rst         (rst),
      .cp2         (cp2),
      .adr         (adr),
      .iore        (iore),
      .iowe        (iowe),
      .dbus_in     (dbus_in),
      .porta_pinx  (porta_pinx),
      .dbus_out    (slv_data[SLV_PORT]),
      .out_en      (slv_en[SLV_PORT]),
      .porta_portx (porta_portx),
      .porta_ddrx  (porta_ddrx)
   );

   timer0 timer0_inst (
      .rst         (rst),
      .cp2         (cp2),
      .adr         (adr),
      .iore        (iore),
      .iowe        (iowe),
      .dbus_in     (dbus_in),
      .tc0_ovf_ack (irq_ack[`TC0_OVF_IRQ]),
      .tc0_cmp_ack (irq_ack[`TC0_CMP_IRQ]),
      .dbus_out    (slv_data[SLV_TMR]),
      .out_en      (slv_en[SLV_TMR]),
      .tc0_ovf_irq (tc0_ovf_irq),
      .tc0_cmp_irq (tc0_cmp_irq)
   );

   wdt wdt_inst (
      .rst       (rst),
      .cp2       (cp2),
      .adr       (adr),
      .iore      (iore),
      .iowe      (iowe),
      .dbus_in   (dbus_in),
      .wdri      (wdri),
      .dbus_out  (slv_data[SLV_WDT]),
      .out_en    (slv_en[SLV_WDT]),
      .wdt_wdovf (wdt_wdovf)
   );

   io_rd_mux #(.N_SLAVES(`IO_SLVS_NUM)) rd_mux_inst (
      .slv_en   (slv_en),
      .slv_data (slv_data),
      .out_en   (out_en),
      .dbus_out (dbus_out)
   );

   // Only the timer 0 lines are live
   always_comb begin
      irqlines               = '0;
      irqlines[`TC0_OVF_IRQ] = tc0_ovf_irq;
      irqlines[`TC0_CMP_IRQ] = tc0_cmp_irq;
   end

endmodule

// ==== src/timer0.sv ====
`timescale 1ns/1ns
`include "avr_io_settings.svh"

module timer0 (
   input  logic                 rst,
   input  logic                 cp2,
   input  avr_io_pkg::io_adr_t  adr,
   input  logic                 iore,
   input  logic                 iowe,
   input  avr_io_pkg::io_data_t dbus_in,
   input  logic                 tc0_ovf_ack,
   input  logic                 tc0_cmp_ack,
   output avr_io_pkg::io_data_t dbus_out,
   output logic                 out_en,
   output logic                 tc0_ovf_irq,
   output logic                 tc0_cmp_irq
);
   import avr_io_pkg::*;

   tmr_cs_t    cs;
   logic [9:0] presc;
   io_data_t   tcnt0;
   io_data_t   tcnt0_nxt;
   io_data_t   ocr0;
   logic       tccr0_wr;
   logic       tcnt0_wr;
   logic       ocr0_wr;
   logic       tick;
   logic       cnt_adv;
   logic       ovf_set;
   logic       cmp_set;

   assign tccr0_wr = iowe && (adr == `TCCR0_ADR);
   assign tcnt0_wr = iowe && (adr == `TCNT0_ADR);
   assign ocr0_wr  = iowe && (adr == `OCR0_ADR);

   // ========================================================================
   // Prescaler tap select
   // ========================================================================
   always_comb begin
      case (cs)
         TMR_CS_CLK:     tick = 1'b1;
         TMR_CS_DIV8:    tick = &presc[2:0];
         TMR_CS_DIV64:   tick = &presc[5:0];
         TMR_CS_DIV256:  tick = &presc[7:0];
         TMR_CS_DIV1024: tick = &presc[9:0];
         default:        tick = 1'b0;
      endcase
   end

   // A CPU write to TCNT0 takes precedence over counting
   assign cnt_adv   = tick && !tcnt0_wr;
   assign tcnt0_nxt = tcnt0 + 1'b1;
   assign ovf_set   = cnt_adv && (tcnt0 == '1);
   assign cmp_set   = cnt_adv && (tcnt0_nxt == ocr0);

   always_ff @(posedge cp2) begin
      if (rst) begin
         cs    <= TMR_CS_STOP;
         presc <= '0;
         tcnt0 <= '0;
         ocr0  <= '0;
      end else begin
         if (tccr0_wr) begin
            cs    <= tmr_cs_t'(dbus_in[2:0]);
            presc <= '0;
         end else begin
            presc <= presc + 1'b1;
         end
         if (tcnt0_wr) begin
            tcnt0 <= dbus_in;
         end else if (cnt_adv) begin
            tcnt0 <= tcnt0_nxt;
         end
         if (ocr0_wr) begin
            ocr0 <= dbus_in;
         end
      end
   end

   // Interrupt flags, a new event beats the ack
   always_ff @(posedge cp2) begin
      if (rst) begin
         tc0_ovf_irq <= 1'b0;
         tc0_cmp_irq <= 1'b0;
      end else begin
         tc0_ovf_irq <= ovf_set || (tc0_ovf_irq && !tc0_ovf_ack);
         tc0_cmp_irq <= cmp_set || (tc0_cmp_irq && !tc0_cmp_ack);
      end
   end

   always_comb begin
      out_en   = iore && ((adr == `TCCR0_ADR) || (adr == `TCNT0_ADR) || (adr == `OCR0_ADR));
      dbus_out = '0;
      if (out_en) begin
         case (adr)
            `TCCR0_ADR: dbus_out = io_data_t'(cs);
            `TCNT0_ADR: dbus_out = tcnt0;
            default:    dbus_out = ocr0;
         endcase
      end
   end

   a_ovf_at_zero: assert property (@(posedge cp2) disable iff (rst)
      $rose(tc0_ovf_irq) |-> (tcnt0 == '0))
      else $error("Overflow flag raised with TCNT0 = %0d", tcnt0);

endmodule

// ==== src/wdt.sv ====
`timescale 1ns/1ns
`include "avr_io_settings.svh"

module wdt (
   input  logic                 rst,
   input  logic                 cp2,
   input  avr_io_pkg::io_adr_t  adr,
   input  logic                 iore,
   input  logic                 iowe,
   input  avr_io_pkg::io_data_t dbus_in,
   input  logic                 wdri,
   output avr_io_pkg::io_data_t dbus_out,
   output logic                 out_en,
   output logic                 wdt_wdovf
);
   import avr_io_pkg::*;

   // Longest period is 2^(7 + base), one spare bit
   localparam int CNT_W = `WDT_BASE_LOG2 + 8;

   logic             wde;
   logic [2:0]       wdp;
   logic             wdtcr_wr;
   logic [CNT_W-1:0] wdt_cnt;
   logic [CNT_W-1:0] wdt_limit;

   assign wdtcr_wr  = iowe && (adr == `WDTCR_ADR);
   assign wdt_limit = (CNT_W'(1) << (wdp + `WDT_BASE_LOG2)) - 1'b1;

   // WDTCR, WDE in bit 3 and WDP in bits 2..0
   always_ff @(posedge cp2) begin
      if (rst) begin
         wde <= 1'b0;
         wdp <= '0;
      end else if (wdtcr_wr) begin
         wde <= dbus_in[3];
         wdp <= dbus_in[2:0];
      end
   end

   // ========================================================================
   // Timeout counter
   // ========================================================================
   always_ff @(posedge cp2) begin
      if (rst || wdri || wdtcr_wr || !wde) begin
         wdt_cnt   <= '0;
         wdt_wdovf <= 1'b0;
      end else if (wdt_cnt == wdt_limit) begin
         // Timeout, restart the period
         wdt_cnt   <= '0;
         wdt_wdovf <= 1'b1;
      end else begin
         wdt_cnt   <= wdt_cnt + 1'b1;
         wdt_wdovf <= 1'b0;
      end
   end

   assign out_en   = iore && (adr == `WDTCR_ADR);
   assign dbus_out = out_en ? io_data_t'({wde, wdp}) : '0;

   a_ovf_single: assert property (@(posedge cp2) disable iff (rst)
      wdt_wdovf |=> !wdt_wdovf)
      else $error("Watchdog timeout pulse longer than one cycle");

endmodule
